// ==== verilog/aes_pkg.sv ====
/*
 * Shared AES-256 encryption definitions
 * Controller state encoding, block sizing and latency constants
 */

package aes_pkg;

    // Controller states
    typedef enum logic [2:0]
    {
        ST_IDLE     = 3'd0,  // Waiting for start
        ST_ADD_KEY  = 3'd1,  // State XOR round key
        ST_SUB      = 3'd2,  // Stream bytes to the S-box
        ST_SUB_WAIT = 3'd3,  // Drain ROM latency
        ST_MIX      = 3'd4,  // Take mixed or shifted block
        ST_DONE     = 3'd5   // Present result
    } aes_state_e;

    // Block and key schedule sizing
    localparam int NUM_BYTES  = 16;  // Bytes per block
    localparam int NUM_ROUNDS = 14;  // AES-256 round count
    localparam int NUM_KEYS   = 15;  // Round keys held in key memory

    localparam int KEY_ADDR_W = 4;   // Key memory address width
    localparam int BYTE_IDX_W = 4;   // Byte step counter width

    // Start edge to done edge
    // Initial key add + 14 rounds of (16 sub + wait + mix + add) + output register
    localparam int ENC_LATENCY = 1 + NUM_ROUNDS * (NUM_BYTES + 3) + 1;

endpackage

// ==== verilog/aes_sbox_rom.sv ====
/*
 * Forward AES S-box lookup, one byte per cycle
 * Registered output gives one cycle of latency
 */

`timescale 1ns/1ps

module aes_sbox_rom
(
    input  logic       clk,
    input  logic       resetn,
    input  logic [7:0] addr,
    output logic [7:0] data
);

    logic [127:0] row;     // One S-box row, selected by the high nibble
    logic [7:0]   lookup;

    // FIPS-197 forward S-box, row x holds entries x0..xf from the left
    always_comb
    begin
        case (addr[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
            default: row = '0;
        endcase
    end

    // Column pick by low nibble, entry 0 sits in the top byte
    assign lookup = row[8 * (15 - addr[3:0]) +: 8];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data <= 8'h00;
        end
        else
        begin
            data <= lookup;  // Substituted byte, one cycle later
        end
    end

endmodule

// ==== verilog/aes_round_ctrl.sv ====
/*
 * AES-256 encryption sequencer
 * Moore FSM issuing load, key add, byte streaming and round write strobes
 */

`timescale 1ns/1ps

module aes_round_ctrl
(
    input  logic clk,
    input  logic resetn,
    input  logic start,       // Begin a block, only seen in idle
    input  logic byte_last,   // Final byte step of SubBytes
    input  logic last_round,  // Round counter at 14
    output logic load,
    output logic add_key,
    output logic sub_active,
    output logic mix_wr,
    output logic round_inc,
    output logic done
);

    aes_pkg::aes_state_e state_q;
    aes_pkg::aes_state_e state_d;

    // State register
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q <= aes_pkg::ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb
    begin
        state_d = state_q;  // Hold by default

        case (state_q)
            aes_pkg::ST_IDLE:
            begin
                // Plaintext is captured on this same edge
                if (start)
                begin
                    state_d = aes_pkg::ST_ADD_KEY;
                end
            end

            aes_pkg::ST_ADD_KEY:
            begin
                // Key 14 was the last one to add
                if (last_round)
                begin
                    state_d = aes_pkg::ST_DONE;
                end
                else
                begin
                    state_d = aes_pkg::ST_SUB;
                end
            end

            aes_pkg::ST_SUB:
            begin
                if (byte_last)  // 16 bytes sent
                begin
                    state_d = aes_pkg::ST_SUB_WAIT;
                end
            end

            aes_pkg::ST_SUB_WAIT:
            begin
                state_d = aes_pkg::ST_MIX;  // Last S-box byte lands now
            end

            aes_pkg::ST_MIX:
            begin
                state_d = aes_pkg::ST_ADD_KEY;
            end

            aes_pkg::ST_DONE:
            begin
                state_d = aes_pkg::ST_IDLE;
            end

            default:
            begin
                state_d = aes_pkg::ST_IDLE;  // Recover from unused codes
            end
        endcase
    end

    // Moore strobes
    assign load       = (state_q == aes_pkg::ST_IDLE);     // Track data_in while idle
    assign add_key    = (state_q == aes_pkg::ST_ADD_KEY);
    assign round_inc  = (state_q == aes_pkg::ST_ADD_KEY);  // Next key after each add
    assign sub_active = (state_q == aes_pkg::ST_SUB);
    assign mix_wr     = (state_q == aes_pkg::ST_MIX);
    assign done       = (state_q == aes_pkg::ST_DONE);     // Registered again at top

endmodule

// ==== verilog/aes_step_counter.sv ====
/*
 * Byte step and round counters, round drives the key memory address
 */

`timescale 1ns/1ps

module aes_step_counter
(
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           load,
    input  logic                           sub_active,
    input  logic                           round_inc,
    output logic [aes_pkg::BYTE_IDX_W-1:0] byte_idx,
    output logic                           byte_last,
    output logic                           last_round,
    output logic [aes_pkg::KEY_ADDR_W-1:0] key_addr
);

    logic [aes_pkg::KEY_ADDR_W-1:0] round_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            byte_idx <= '0;
            round_q  <= '0;
        end
        else
        begin
            // Steps 0..15 during SubBytes, parked at 0 otherwise
            byte_idx <= sub_active ? byte_idx + 1'b1 : '0;

            if (load)
            begin
                round_q <= '0;
            end
            else if (round_inc && (round_q != aes_pkg::KEY_ADDR_W'(aes_pkg::NUM_KEYS - 1)))
            begin
                round_q <= round_q + 1'b1;  // Holds at the final key
            end
        end
    end

    assign byte_last  = (byte_idx == aes_pkg::BYTE_IDX_W'(aes_pkg::NUM_BYTES - 1));
    assign last_round = (round_q == aes_pkg::KEY_ADDR_W'(aes_pkg::NUM_ROUNDS));
    assign key_addr   = round_q;

endmodule

// ==== verilog/aes_state_reg.sv ====
/*
 * 16-byte cipher state register
 * Plaintext load, AddRoundKey, round write-back and byte-serial S-box feed
 */

`timescale 1ns/1ps

module aes_state_reg
(
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           load,
    input  logic                           add_key,
    input  logic                           mix_wr,
    input  logic [127:0]                   data_in,
    input  logic [127:0]                   round_key,
    input  logic [127:0]                   mixed,     // Round result from shift/mix
    input  logic [aes_pkg::BYTE_IDX_W-1:0] byte_idx,
    output logic [7:0]                     sub_byte,
    output logic [127:0]                   state
);

    logic [7:0] state_bytes [aes_pkg::NUM_BYTES];  // Byte view, byte 0 on top

    // Only one strobe is active per cycle, priority is a formality
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
        end
        else if (load)
        begin
            state <= data_in;              // Plaintext
        end
        else if (add_key)
        begin
            state <= state ^ round_key;    // AddRoundKey
        end
        else if (mix_wr)
        begin
            state <= mixed;                // End of SubBytes/ShiftRows/MixColumns
        end
    end

    // Split the block into bytes in FIPS column order
    always_comb
    begin
        for (int i = 0; i < aes_pkg::NUM_BYTES; i++)
        begin
            state_bytes[i] = state[127 - 8 * i -: 8];
        end
    end

    // Byte at the current step goes to the S-box
    assign sub_byte = state_bytes[byte_idx];

endmodule

// ==== verilog/aes_shift_mix.sv ====
/*
 * ShiftRows by write position and MixColumns over the collected block
 * Final round passes the shifted block unmixed
 */

`timescale 1ns/1ps

module aes_shift_mix
(
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           sub_active,
    input  logic [aes_pkg::BYTE_IDX_W-1:0] byte_idx,
    input  logic [7:0]                     sbox_byte,   // One cycle behind byte_idx
    input  logic                           last_round,
    output logic [127:0]                   mixed
);

    logic                           sub_d;   // sub_active aligned with ROM output
    logic [aes_pkg::BYTE_IDX_W-1:0] idx_d;   // byte_idx aligned with ROM output
    logic [7:0]                     shifted [aes_pkg::NUM_BYTES];

    // GF(2^8) multiply by 2
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Row r, column c moves to column c - r
    function automatic logic [3:0] shift_pos(input logic [3:0] idx);
        logic [1:0] row;
        logic [1:0] col;
        row = idx[1:0];
        col = idx[3:2] - row;  // Wraps mod 4
        return {col, row};
    endfunction

    // Match the S-box register stage
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sub_d <= 1'b0;
            idx_d <= '0;
        end
        else
        begin
            sub_d <= sub_active;
            idx_d <= byte_idx;
        end
    end

    // Substituted bytes land directly at their shifted position
    always_ff @(posedge clk)
    begin
        if (sub_d)
        begin
            shifted[shift_pos(idx_d)] <= sbox_byte;
        end
    end

    // MixColumns per column, bypassed in the last round
    always_comb
    begin : mix_cols
        logic [7:0] a0, a1, a2, a3;
        logic [7:0] b0, b1, b2, b3;

        for (int c = 0; c < 4; c++)
        begin
            a0 = shifted[4 * c];
            a1 = shifted[4 * c + 1];
            a2 = shifted[4 * c + 2];
            a3 = shifted[4 * c + 3];

            // Matrix rows 2 3 1 1 rotated
            b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);

            if (last_round)
            begin
                mixed[127 - 32 * c -: 32] = {a0, a1, a2, a3};  // ShiftRows only
            end
            else
            begin
                mixed[127 - 32 * c -: 32] = {b0, b1, b2, b3};
            end
        end
    end

endmodule

// ==== verilog/aes256_enc.sv ====
/*
 * AES-256 block encryption core, round keys from external key memory
 */

`timescale 1ns/1ps

module aes256_enc
(
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           start,
    input  logic [127:0]                   data_in,
    input  logic [127:0]                   round_key,  // Combinational from key memory
    output logic [aes_pkg::KEY_ADDR_W-1:0] key_addr,
    output logic [127:0]                   data_out,
    output logic                           done
);

    logic                           load;
    logic                           add_key;
    logic                           sub_active;
    logic                           mix_wr;
    logic                           round_inc;
    logic                           fin;         // Controller in ST_DONE
    logic [aes_pkg::BYTE_IDX_W-1:0] byte_idx;
    logic                           byte_last;
    logic                           last_round;
    logic [7:0]                     sub_byte;
    logic [7:0]                     sbox_byte;
    logic [127:0]                   state;
    logic [127:0]                   mixed;

    aes_round_ctrl u_ctrl
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .byte_last  (byte_last),
        .last_round (last_round),
        .load       (load),
        .add_key    (add_key),
        .sub_active (sub_active),
        .mix_wr     (mix_wr),
        .round_inc  (round_inc),
        .done       (fin)
    );

    aes_step_counter u_cnt
    (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .sub_active (sub_active),
        .round_inc  (round_inc),
        .byte_idx   (byte_idx),
        .byte_last  (byte_last),
        .last_round (last_round),
        .key_addr   (key_addr)
    );

    aes_state_reg u_state
    (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .add_key   (add_key),
        .mix_wr    (mix_wr),
        .data_in   (data_in),
        .round_key (round_key),
        .mixed     (mixed),
        .byte_idx  (byte_idx),
        .sub_byte  (sub_byte),
        .state     (state)
    );

    aes_sbox_rom u_sbox
    (
        .clk    (clk),
        .resetn (resetn),
        .addr   (sub_byte),
        .data   (sbox_byte)
    );

    aes_shift_mix u_mix
    (
        .clk        (clk),
        .resetn     (resetn),
        .sub_active (sub_active),
        .byte_idx   (byte_idx),
        .sbox_byte  (sbox_byte),
        .last_round (last_round),
        .mixed      (mixed)
    );

    // Output register, data_out holds until the next block completes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_out <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= fin;            // One-cycle pulse
            if (fin)
            begin
                data_out <= state;  // State already holds the final key add
            end
        end
    end

endmodule

// ==== tests/tb_aes256_enc.sv ====
/*
 * Testbench for the AES-256 encryption core
 * Key memory model, FIPS-197 vector stimulus, concurrent checks and reporting
 */

`timescale 1ns/1ps

module tb_aes256_enc;

    localparam logic [127:0] PLAIN   = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] CIPHER  = 128'h8ea2b7ca516745bfeafc49904b496089;
    localparam int           KEY_MAX = aes_pkg::NUM_KEYS - 1;
    localparam int           LIMIT   = 3 * (aes_pkg::ENC_LATENCY + 40) * 4;  // Watchdog cycles
    localparam int           NCHK    = 7;

    logic         clk;
    logic         resetn;
    logic         start;
    logic [127:0] data_in;
    logic [127:0] round_key;
    logic [3:0]   key_addr;
    logic [127:0] data_out;
    logic         done;
    logic [127:0] key_mem [aes_pkg::NUM_KEYS];
    logic         busy;                  // Reference view of a block in flight
    logic         started;               // Some start was sampled
    int           lat;                   // Edges since the accepted start
    int           cycles;
    int           pass_cnt [NCHK] = '{default: 0};
    int           fail_cnt [NCHK] = '{default: 0};

    aes256_enc UUT (.*);

    initial $readmemh("tests/aes256_round_keys.hex", key_mem);
    assign round_key = key_mem[key_addr];  // Combinational key memory

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // A start counts only when no block is in flight
    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy    <= 1'b0;
            started <= 1'b0;
            lat     <= aes_pkg::ENC_LATENCY + 1;
        end
        else if (!busy && start)
        begin
            busy    <= 1'b1;
            started <= 1'b1;
            lat     <= 0;
        end
        else
        begin
            lat <= lat + 1;
            if (busy && lat == aes_pkg::ENC_LATENCY - 1)
                busy <= 1'b0;  // Core is back in idle after this edge
        end
    end

    chk_reset: assert property (@(posedge clk) disable iff (!resetn)
        !started |-> (!done && key_addr == '0 && data_out == '0)) pass_cnt[0]++;
        else flag_mismatch(0, "outputs left their reset values before the first start");
    chk_cipher: assert property (@(posedge clk) disable iff (!resetn)
        done |-> data_out == CIPHER) pass_cnt[1]++;
        else flag_mismatch(1, $sformatf("data_out %h, expected %h", $sampled(data_out), CIPHER));
    chk_latency: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (!busy && lat == aes_pkg::ENC_LATENCY)) pass_cnt[2]++;
        else flag_mismatch(2, $sformatf("done after %0d cycles", $sampled(lat)));
    chk_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done) pass_cnt[3]++;
        else flag_mismatch(3, "done high for more than one cycle");
    // Key address only steps up by one or restarts at 0
    chk_key_step: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= KEY_MAX && (key_addr == $past(key_addr)
        || key_addr == $past(key_addr) + 1'b1 || key_addr == '0)) pass_cnt[4]++;
        else flag_mismatch(4, $sformatf("key_addr jumped to %0d", $sampled(key_addr)));
    chk_key_last: assert property (@(posedge clk) disable iff (!resetn)
        done |-> key_addr == KEY_MAX) pass_cnt[5]++;
        else flag_mismatch(5, "final round key was not reached");
    chk_hold: assert property (@(posedge clk) disable iff (!resetn)
        $changed(data_out) |-> done) pass_cnt[6]++;
        else flag_mismatch(6, "data_out changed between done pulses");

    task automatic flag_mismatch(input int idx, input string msg);
        fail_cnt[idx]++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    function automatic int sum_counts(input int counts [NCHK]);
        int sum;
        sum = 0;
        foreach (counts[i])
            sum += counts[i];
        return sum;
    endfunction

    // Random number of idle cycles with junk on data_in
    task automatic idle_gap(input int lo, input int hi);
        int n;
        n = $urandom_range(hi, lo);
        repeat (n)
        begin
            @(posedge clk);
            data_in <= {$urandom, $urandom, $urandom, $urandom};
        end
    endtask

    task automatic start_block();
        @(posedge clk);
        start   <= 1'b1;
        data_in <= PLAIN;
        @(posedge clk);  // Start sampled here
        start   <= 1'b0;
        data_in <= {$urandom, $urandom, $urandom, $urandom};
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (!done)
            @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int fails_before);
        @(negedge clk);  // Let this edge's checks finish
        $display("[%0d] %s: %s", num, name,
                 (sum_counts(fail_cnt) == fails_before) ? "pass" : "errors seen");
    endtask

    initial
    begin
        int fails_before;
        void'($urandom(94638));
        start   = 1'b0;
        data_in = '0;
        resetn  = 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;

        fails_before = sum_counts(fail_cnt);
        idle_gap(10, 40);
        report_test(1, "reset values until first start", fails_before);

        fails_before = sum_counts(fail_cnt);
        start_block();
        wait_done();
        report_test(2, "single block, latency and key order", fails_before);

        // Junk starts stop well before the core returns to idle
        fails_before = sum_counts(fail_cnt);
        start_block();
        repeat (aes_pkg::ENC_LATENCY - 20)
        begin
            @(posedge clk);
            start   <= 1'($urandom_range(1, 0));
            data_in <= {$urandom, $urandom, $urandom, $urandom};
        end
        @(posedge clk);
        start <= 1'b0;
        wait_done();
        report_test(3, "start ignored while busy", fails_before);

        fails_before = sum_counts(fail_cnt);
        idle_gap(5, 25);
        start_block();
        wait_done();
        idle_gap(5, 25);
        start_block();
        wait_done();
        idle_gap(4, 8);
        report_test(4, "back-to-back blocks", fails_before);

        $display("Checks passed: %0d, failed: %0d", sum_counts(pass_cnt), sum_counts(fail_cnt));
        if (sum_counts(fail_cnt) == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/aes_pkg.sv
verilog/aes_sbox_rom.sv
verilog/aes_round_ctrl.sv
verilog/aes_step_counter.sv
verilog/aes_state_reg.sv
verilog/aes_shift_mix.sv
verilog/aes256_enc.sv
tests/tb_aes256_enc.sv

// ==== Bender.yml ====
package:
  name: aes256_enc

sources:
  - verilog/aes_pkg.sv
  - verilog/aes_sbox_rom.sv
  - verilog/aes_round_ctrl.sv
  - verilog/aes_step_counter.sv
  - verilog/aes_state_reg.sv
  - verilog/aes_shift_mix.sv
  - verilog/aes256_enc.sv
  - target: test
    files:
      - tests/tb_aes256_enc.sv

// ==== tests/aes256_round_keys.hex ====
// One 128-bit round key per line, key address 0 to 14, byte 0 in the leftmost two digits
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36
